//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f decodeUnit.f --top-module decodeUnit
	verilator --lint-only --timing --assert -f decodeUnit.f --top-module decodeUnitTb

sim:
	verilator --binary --timing --assert -f decodeUnit.f --top-module decodeUnitTb \
		-o decodeUnitSim
	./obj_dir/decodeUnitSim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- decodeUnit.f
hw/decodePkg.sv
hw/controlDecode.sv
hw/regFileBypass.sv
hw/immGen.sv
hw/decodeUnit.sv
verif/decodeUnit_sva.sv
verif/decodeUnitTb.sv

//--- hw/controlDecode.sv
`timescale 1ns/1ps

module controlDecode import decodePkg::*; (
    input  word_t   instr,          // Current instruction
    output logic    i1Fmt,          // I-format 1, 5-bit immediate
    output logic    zeroExt,        // Zero-extend the immediate
    output logic    jumpReg,        // JR/JALR, 8-bit displacement
    output regSel_t writeRegOut,    // Destination register
    output logic    err             // Unknown opcode
);

    opcode_t opcode;
    regSel_t rsField;
    regSel_t rtField;
    regSel_t rdField;
    logic    linkOp;                // Writes the link register
    logic    stuOp;                 // Store with update writes back Rs
    logic    rFmtOp;

    assign opcode  = opcode_t'(instr[OPC_MSB:OPC_LSB]);
    assign rsField = instr[RS_MSB -: $bits(regSel_t)];
    assign rtField = instr[RT_MSB -: $bits(regSel_t)];
    assign rdField = instr[RD_MSB -: $bits(regSel_t)];

    // Per-opcode control flags
    always_comb begin
        i1Fmt   = 1'b0;             // Defaults cover I2, J and R formats
        zeroExt = 1'b0;
        jumpReg = 1'b0;
        linkOp  = 1'b0;
        stuOp   = 1'b0;
        rFmtOp  = 1'b0;
        err     = 1'b0;
        case (opcode)
            HALT, NOP, J: begin
                // Nothing to flag
            end
            JR: begin
                jumpReg = 1'b1;
            end
            JAL: begin
                linkOp = 1'b1;
            end
            JALR: begin
                jumpReg = 1'b1;
                linkOp  = 1'b1;
            end
            ADDI, SUBI, ST, LD: begin
                i1Fmt = 1'b1;       // Signed 5-bit immediate
            end
            XORI, ANDNI: begin
                i1Fmt   = 1'b1;
                zeroExt = 1'b1;     // Logical ops take unsigned immediate
            end
            STU: begin
                i1Fmt = 1'b1;
                stuOp = 1'b1;
            end
            BEQZ, BNEZ, BLTZ, BGEZ, LBI: begin
                // Signed 8-bit immediate
            end
            SLBI: begin
                zeroExt = 1'b1;     // Shift-and-load takes unsigned byte
            end
            RFMT: begin
                rFmtOp = 1'b1;
            end
            default: begin
                err = 1'b1;         // Encoding not in the ISA
            end
        endcase
    end

    // Destination select, highest priority first
    always_comb begin
        if (linkOp) begin
            writeRegOut = regSel_t'(LINK_REG);
        end else if (stuOp) begin
            writeRegOut = rsField;  // Updated base address
        end else if (i1Fmt) begin
            writeRegOut = rtField;
        end else if (rFmtOp) begin
            writeRegOut = rdField;
        end else begin
            writeRegOut = rsField;  // I2 formats such as LBI, SLBI
        end
    end

endmodule

//--- hw/decodePkg.sv
package decodePkg;

    // Register file geometry
    localparam int NUM_REGS = 8;               // Architectural registers
    localparam int LINK_REG = 7;               // JAL and JALR return address target

    // Instruction field positions
    localparam int OPC_MSB  = 15;              // Opcode top bit
    localparam int OPC_LSB  = 11;              // Opcode bottom bit
    localparam int RS_MSB   = 10;              // Rs, bits 10..8
    localparam int RT_MSB   = 7;               // Rt or I1 Rd, bits 7..5
    localparam int RD_MSB   = 4;               // R-format Rd, bits 4..2
    localparam int IMM5_W   = 5;               // I1 immediate
    localparam int IMM8_W   = 8;               // I2 immediate, JR/JALR displacement
    localparam int DISP11_W = 11;              // J-format displacement

    typedef logic [15:0] word_t;                       // Data or instruction word
    typedef logic [$clog2(NUM_REGS)-1:0] regSel_t;     // Register number

    // Opcode encodings, bits 15..11
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        J     = 5'b00100,
        JR    = 5'b00101,
        JAL   = 5'b00110,
        JALR  = 5'b00111,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        BLTZ  = 5'b01110,
        BGEZ  = 5'b01111,
        ST    = 5'b10000,
        LD    = 5'b10001,
        SLBI  = 5'b10010,
        STU   = 5'b10011,
        LBI   = 5'b11000,
        RFMT  = 5'b11011                       // All R-format ALU ops share this
    } opcode_t;

endpackage

//--- hw/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit import decodePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  word_t   instr,          // Held stable by fetch for the cycle
    input  logic    writeEn,        // Write-back strobe
    input  regSel_t writeSel,
    input  word_t   writeData,
    output word_t   readData1,      // Rt in R-format, Rd in I1
    output word_t   readData2,      // Rs
    output word_t   immVal,
    output word_t   jumpDist,
    output regSel_t writeRegOut,
    output logic    err
);

    regSel_t readSel1;
    regSel_t readSel2;
    logic    i1Fmt;
    logic    zeroExt;
    logic    jumpReg;

    // Read selects come straight from the instruction
    assign readSel1 = instr[RT_MSB -: $bits(regSel_t)];
    assign readSel2 = instr[RS_MSB -: $bits(regSel_t)];

    controlDecode controlDecode_inst (
        .instr       (instr),
        .i1Fmt       (i1Fmt),
        .zeroExt     (zeroExt),
        .jumpReg     (jumpReg),
        .writeRegOut (writeRegOut),
        .err         (err)
    );

    regFileBypass regFileBypass_inst (
        .clk       (clk),
        .rstN      (rstN),
        .writeEn   (writeEn),
        .writeSel  (writeSel),
        .readSel1  (readSel1),
        .readSel2  (readSel2),
        .writeData (writeData),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    // Immediate and jump offset, driven by the decoded format
    immGen immGen_inst (
        .instr    (instr),
        .i1Fmt    (i1Fmt),
        .zeroExt  (zeroExt),
        .jumpReg  (jumpReg),
        .immVal   (immVal),
        .jumpDist (jumpDist)
    );

endmodule

//--- hw/immGen.sv
`timescale 1ns/1ps

module immGen import decodePkg::*; (
    input  word_t instr,
    input  logic  i1Fmt,            // Use the 5-bit field
    input  logic  zeroExt,          // Unsigned immediate
    input  logic  jumpReg,          // JR/JALR displacement
    output word_t immVal,
    output word_t jumpDist
);

    word_t imm5Sext;
    word_t imm5Zext;
    word_t imm8Sext;                // Also the JR/JALR displacement
    word_t imm8Zext;
    word_t disp11Sext;

    // Extensions of the low instruction bits
    assign imm5Sext   = {{($bits(word_t) - IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
    assign imm5Zext   = {{($bits(word_t) - IMM5_W){1'b0}}, instr[IMM5_W-1:0]};
    assign imm8Sext   = {{($bits(word_t) - IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
    assign imm8Zext   = {{($bits(word_t) - IMM8_W){1'b0}}, instr[IMM8_W-1:0]};
    assign disp11Sext = {{($bits(word_t) - DISP11_W){instr[DISP11_W-1]}},
                         instr[DISP11_W-1:0]};

    // Immediate by format and extension
    always_comb begin
        case ({i1Fmt, zeroExt})
            2'b11: begin
                immVal = imm5Zext;      // XORI, ANDNI
            end
            2'b10: begin
                immVal = imm5Sext;      // ADDI, SUBI, ST, LD, STU
            end
            2'b01: begin
                immVal = imm8Zext;      // SLBI
            end
            default: begin
                immVal = imm8Sext;      // LBI, branches, JR/JALR
            end
        endcase
    end

    // Register jumps carry only 8 bits of offset
    assign jumpDist = jumpReg ? imm8Sext : disp11Sext;

endmodule

//--- hw/regFileBypass.sv
`timescale 1ns/1ps

module regFileBypass import decodePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    writeEn,        // Single-cycle write strobe
    input  regSel_t writeSel,
    input  regSel_t readSel1,
    input  regSel_t readSel2,
    input  word_t   writeData,
    output word_t   readData1,
    output word_t   readData2
);

    word_t regArr [NUM_REGS];       // Stored register values
    logic  hit1;                    // Port 1 reads the register being written
    logic  hit2;

    // One entry per register, each with its own write decode
    genvar i;
    generate
        for (i = 0; i < NUM_REGS; i++) begin : regEntry
            logic entryWe;

            assign entryWe = writeEn && (writeSel == regSel_t'(i));

            always_ff @(posedge clk) begin
                if (!rstN) begin
                    regArr[i] <= '0;                // Registers come up zero
                end else if (entryWe) begin
                    regArr[i] <= writeData;
                end
            end
        end
    endgenerate

    // Same-cycle write forwarding
    assign hit1 = writeEn && (readSel1 == writeSel);
    assign hit2 = writeEn && (readSel2 == writeSel);

    assign readData1 = hit1 ? writeData : regArr[readSel1];
    assign readData2 = hit2 ? writeData : regArr[readSel2];

endmodule

//--- verif/decodeUnitTb.sv
`timescale 1ns/1ps

module decodeUnitTb import decodePkg::*; ();

    localparam int CLK_HALF     = 4;    // 8 ns period
    localparam int RESET_CYCLES = 8;
    localparam int RUN_LIMIT    = 200;  // Watchdog limit in cycles

    logic    clk;
    logic    rstN;
    word_t   instr;
    logic    writeEn;
    regSel_t writeSel;
    word_t   writeData;
    word_t   readData1;
    word_t   readData2;
    word_t   immVal;
    word_t   jumpDist;
    regSel_t writeRegOut;
    logic    err;

    decodeUnit decodeUnit_inst (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (instr),
        .writeEn     (writeEn),
        .writeSel    (writeSel),
        .writeData   (writeData),
        .readData1   (readData1),
        .readData2   (readData2),
        .immVal      (immVal),
        .jumpDist    (jumpDist),
        .writeRegOut (writeRegOut),
        .err         (err)
    );

    bind decodeUnit decodeUnitSva decodeUnitSva_inst (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (instr),
        .writeEn     (writeEn),
        .writeSel    (writeSel),
        .writeData   (writeData),
        .readData1   (readData1),
        .readData2   (readData2),
        .writeRegOut (writeRegOut)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string testName, input string field,
                              input word_t expVal, input word_t actVal);
        assert (actVal === expVal) else begin
            failRun($sformatf("error %s %s expected %h actual %h",
                              testName, field, expVal, actVal));
        end
    endtask

    initial begin
        for (int c = 0; c < RUN_LIMIT; c++) begin
            @(posedge clk);
        end
        failRun("simulation ran past its cycle limit without finishing");
    end

    initial begin
        int    fd;
        int    fields;
        int    testCount;
        string line;
        string testName;
        string op;
        word_t inInstr;
        word_t inSel;
        word_t inData;
        word_t inWe;
        word_t expRd1;
        word_t expRd2;
        word_t expImm;
        word_t expJump;
        word_t expWr;
        word_t expErr;

        rstN      = 1'b0;           // Reset held from time zero
        instr     = '0;
        writeEn   = 1'b0;
        writeSel  = '0;
        writeData = '0;
        testCount = 0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
        end
        #1 rstN = 1'b1;

        fd = $fopen("verif/decode_tests.txt", "r");
        if (fd == 0) begin
            failRun("could not open the test data file verif/decode_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;       // Blank or column description
                end
                fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h",
                                 testName, op, inInstr, inSel, inData, inWe,
                                 expRd1, expRd2, expImm, expJump, expWr, expErr);
                assert (fields == 12) else begin
                    failRun($sformatf("malformed line in the test data file: %s", line));
                end
                @(posedge clk);
                #1;                 // Drive just after the edge
                instr     = inInstr;
                writeSel  = regSel_t'(inSel);
                writeData = inData;
                writeEn   = inWe[0];
                testCount++;
                if (op == "D") begin
                    #1;             // Combinational settle
                    checkValue(testName, "readData1", expRd1, readData1);
                    checkValue(testName, "readData2", expRd2, readData2);
                    checkValue(testName, "immVal", expImm, immVal);
                    checkValue(testName, "jumpDist", expJump, jumpDist);
                    checkValue(testName, "writeRegOut", expWr, word_t'(writeRegOut));
                    checkValue(testName, "err", expErr, word_t'(err));
                end else if (op != "W") begin
                    failRun($sformatf("unknown operation %s in test %s", op, testName));
                end
            end
            @(posedge clk);
            #1 writeEn = 1'b0;      // Last strobe has landed
            $fclose(fd);
            if (testCount == 0) begin
                failRun("the test data file held no test lines");
            end else begin
                $display("TEST PASS");
                $finish;
            end
        end
    end

endmodule

//--- verif/decodeUnit_sva.sv
`timescale 1ns/1ps

module decodeUnitSva import decodePkg::*; (
    input logic    clk,
    input logic    rstN,
    input word_t   instr,
    input logic    writeEn,
    input regSel_t writeSel,
    input word_t   writeData,
    input word_t   readData1,
    input word_t   readData2,
    input regSel_t writeRegOut
);

    logic    noWriteSinceReset;     // Register file still at its reset value
    opcode_t opcode;

    assign opcode = opcode_t'(instr[OPC_MSB:OPC_LSB]);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            noWriteSinceReset <= 1'b1;
        end else if (writeEn) begin
            noWriteSinceReset <= 1'b0;  // First write-back dirties the file
        end
    end

    // Both ports read zero until something is written
    readsZeroAfterReset: assert property (@(posedge clk) disable iff (!rstN)
        (noWriteSinceReset && !writeEn) |-> (readData1 == '0 && readData2 == '0))
        else $error("Register read is not zero after reset");

    // Port 1 forwards the value being written
    bypassPort1: assert property (@(posedge clk) disable iff (!rstN)
        (writeEn && instr[RT_MSB -: $bits(regSel_t)] == writeSel) |-> readData1 == writeData)
        else $error("Port 1 did not forward the write data");

    bypassPort2: assert property (@(posedge clk) disable iff (!rstN)
        (writeEn && instr[RS_MSB -: $bits(regSel_t)] == writeSel) |-> readData2 == writeData)
        else $error("Port 2 did not forward the write data");

    linkDestination: assert property (@(posedge clk) disable iff (!rstN)
        (opcode == JAL || opcode == JALR) |-> writeRegOut == regSel_t'(LINK_REG))
        else $error("Jump and link does not target the link register");

endmodule

//--- verif/decode_tests.txt
# name op instr writeSel writeData writeEn | expected readData1 readData2 immVal jumpDist
# writeRegOut err; op W writes for one cycle, op D checks; all numbers in hex
rstRfmt     D D94C 0 0000 0 0000 0000 004C 014C 3 0
rstRfmt2    D DFD4 0 0000 0 0000 0000 FFD4 FFD4 5 0
wrR0        W 0800 0 0101 1 0000 0000 0000 0000 0 0
wrR1        W 0800 1 1212 1 0000 0000 0000 0000 0 0
wrR2        W 0800 2 2323 1 0000 0000 0000 0000 0 0
wrR3        W 0800 3 3434 1 0000 0000 0000 0000 0 0
wrR4        W 0800 4 4545 1 0000 0000 0000 0000 0 0
wrR5        W 0800 5 5656 1 0000 0000 0000 0000 0 0
wrR6        W 0800 6 6767 1 0000 0000 0000 0000 0 0
wrR7        W 0800 7 7878 1 0000 0000 0000 0000 0 0
rdR1R0      D D820 0 0000 0 1212 0101 0020 0020 0 0
rdR3R2      D DA60 0 0000 0 3434 2323 0060 0260 0 0
rdR5R4      D DCA0 0 0000 0 5656 4545 FFA0 FCA0 0 0
rdR7R6      D DEE0 0 0000 0 7878 6767 FFE0 FEE0 0 0
bypassRt    D DB40 2 BEEF 1 BEEF 3434 0040 0340 0 0
bypassRs    D DD80 5 CAFE 1 4545 CAFE FF80 FD80 0 0
afterBypass D DD40 0 0000 0 BEEF CAFE 0040 FD40 0 0
addiNeg     D 4153 0 0000 0 BEEF 1212 FFF3 0153 2 0
xoriZext    D 539F 0 0000 0 4545 3434 001F 039F 4 0
lbiSext     D C69C 0 0000 0 4545 6767 FF9C FE9C 6 0
slbiZext    D 97A5 0 0000 0 CAFE 7878 00A5 FFA5 7 0
stuRs       D 9964 0 0000 0 3434 1212 0004 0164 1 0
jalLink     D 35A3 0 0000 0 CAFE CAFE FFA3 FDA3 7 0
jalrLink    D 3A85 0 0000 0 4545 BEEF FF85 FF85 7 0
jPos        D 23F0 0 0000 0 7878 3434 FFF0 03F0 3 0
jrByte      D 2C7F 0 0000 0 3434 4545 007F 007F 4 0
beqz        D 62FE 0 0000 0 7878 BEEF FFFE 02FE 2 0
halt        D 0000 0 0000 0 0101 0101 0000 0000 0 0
illegal     D F800 0 0000 0 0101 0101 0000 0000 0 1
illegal2    D 1120 0 0000 0 1212 1212 0020 0120 1 1
